/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = lspcTb
FILELIST = filelist.f
OBJDIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# Exit status of the simulation is the test result
run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* filelist.f */
+incdir+include
logic/lspcPkg.sv
logic/cpuRegs.sv
logic/videoSync.sv
logic/vramCycle.sv
logic/pBusDriver.sv
logic/lspcTop.sv
sim/lspcTb.sv

/* include/lspc_defs.svh */
`ifndef LSPC_DEFS_SVH
`define LSPC_DEFS_SVH

// Raster geometry, one fixed mode only
`define LSPC_H_TOTAL      9'd384 // Pixels per line, 4 clocks each
`define LSPC_V_TOTAL      9'd264 // Lines per frame
`define LSPC_VBL_START    9'd224 // First blanked line
`define LSPC_HSYNC_END    9'd32  // HSYNC high for pixels 0..31
`define LSPC_VSYNC_LINES  9'd4   // Vsync on the last lines of the frame

// Video RAM
`define LSPC_VRAM_WORDS   32768   // 32K words
`define LSPC_FIX_BASE     15'h7000 // Fix map, 48 columns of 32 words

// CPU register indices
// 0 and 1 both read back the prefetch buffer
`define LSPC_REG_ADDR     2'd0 // VRAM address
`define LSPC_REG_DATA     2'd1 // VRAM data
`define LSPC_REG_MOD      2'd2 // Address modulo
`define LSPC_REG_MODE     2'd3 // Mode / status

`endif

/* logic/cpuRegs.sv */
`timescale 1ns/1ns
`default_nettype none
`include "lspc_defs.svh"

module cpuRegs
(
	input wire CLK_24M,
	input wire arstN,
	input wire cpuValid,
	input wire cpuWrite,
	input wire lspcPkg::regSelT cpuSel,
	input wire lspcPkg::vramDataT cpuWrData,
	output logic cpuReady,
	output lspcPkg::vramDataT cpuRdData,
	input wire lspcPkg::vCountT vCount, // For MODE readback
	input wire lspcPkg::aaCountT aaCount,
	input wire vramAck,
	input wire lspcPkg::vramDataT vramRdData,
	output logic vramReq,
	output logic vramWe,
	output lspcPkg::vramAddrT vramAddr,
	output lspcPkg::vramDataT vramWrData,
	output logic [7:0] aaSpeed,
	output logic aaDisable
);
	import lspcPkg::*;

	cpuStateT state;
	vramDataT vramMod; // Full 16 bits kept for readback
	vramDataT rdBuf;   // Prefetched word
	logic xfer;
	logic wrXfer;

	// Busy while any VRAM access is in flight
	assign cpuReady = (state == IDLE);
	assign xfer = cpuValid & cpuReady;
	assign wrXfer = xfer & cpuWrite;

	// Read mux, valid as soon as cpuSel is
	always_comb
	begin
		case (cpuSel)
			`LSPC_REG_MOD: cpuRdData = vramMod;
			`LSPC_REG_MODE: cpuRdData = {vCount, 4'b0000, aaCount}; // Line in 15..7
			default: cpuRdData = rdBuf; // ADDR and DATA
		endcase
	end

	// Access sequencer and control registers
	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= IDLE;
			vramReq <= 1'b0;
			vramWe <= 1'b0;
			vramAddr <= '0;
			vramMod <= '0;
			aaSpeed <= '0;
			aaDisable <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
					if (wrXfer)
					begin
						case (cpuSel)
							`LSPC_REG_ADDR:
							begin
								vramAddr <= cpuWrData[14:0]; // Bit 15 ignored
								vramReq <= 1'b1;             // Prefetch
								vramWe <= 1'b0;
								state <= RDWAIT;
							end
							`LSPC_REG_DATA:
							begin
								vramReq <= 1'b1;
								vramWe <= 1'b1;
								state <= WRWAIT;
							end
							`LSPC_REG_MOD: vramMod <= cpuWrData;
							default:
							begin
								aaSpeed <= cpuWrData[15:8]; // Frames per step minus one
								aaDisable <= cpuWrData[3];
							end
						endcase
					end
				WRWAIT:
					if (vramAck)
					begin
						// Step by modulo, wraps at 15 bits
						vramAddr <= vramAddr + vramMod[14:0];
						vramWe <= 1'b0; // Request stays up for the prefetch
						state <= RDWAIT;
					end
				RDWAIT:
					if (vramAck)
					begin
						vramReq <= 1'b0;
						state <= IDLE;
					end
				default: state <= IDLE;
			endcase
		end
	end

	// Data buffers
	always_ff @(posedge CLK_24M)
	begin
		if (wrXfer && (cpuSel == `LSPC_REG_DATA))
			vramWrData <= cpuWrData;
		if ((state == RDWAIT) && vramAck)
			rdBuf <= vramRdData; // Prefetch lands
	end

	// Request held with the same address and direction until acknowledged
	assert property (@(posedge CLK_24M) disable iff (!arstN)
		vramReq && !vramAck |=> vramReq && $stable(vramAddr) && $stable(vramWe));

	// Refused request held by the master until taken
	assert property (@(posedge CLK_24M) disable iff (!arstN)
		cpuValid && !cpuReady |=> cpuValid && $stable(cpuWrite) && $stable(cpuSel) &&
		$stable(cpuWrData));

endmodule

`default_nettype wire

/* logic/lspcPkg.sv */
`default_nettype none

package lspcPkg;

	// VRAM side
	typedef logic [14:0] vramAddrT; // Word address, 32K
	typedef logic [15:0] vramDataT; // One VRAM word

	// Raster counters
	typedef logic [8:0] hCountT; // Pixel in line
	typedef logic [8:0] vCountT; // Line in frame

	// CPU port register select
	typedef logic [1:0] regSelT;

	// Auto-animation tile counter
	typedef logic [2:0] aaCountT;

	// Fix map word fields
	typedef logic [11:0] fixTileT; // Bits 11..0
	typedef logic [3:0] palT;      // Bits 15..12

	// CPU access flow
	// Write goes WRWAIT then RDWAIT for the prefetch at the new address
	typedef enum logic [1:0]
	{
		IDLE,   // Ready for a transfer
		WRWAIT, // VRAM write pending
		RDWAIT  // Prefetch pending
	} cpuStateT;

endpackage

`default_nettype wire

/* logic/lspcTop.sv */
`timescale 1ns/1ns
`default_nettype none

module lspcTop
(
	input wire CLK_24M,
	input wire arstN,
	input wire cpuValid,
	input wire cpuWrite,
	input wire lspcPkg::regSelT cpuSel,
	input wire lspcPkg::vramDataT cpuWrData,
	output logic cpuReady,
	output lspcPkg::vramDataT cpuRdData,
	output logic hsync,
	output logic vblank,
	output logic csync,
	output logic pixLoad,
	output logic [15:0] pBusAddr,
	output lspcPkg::palT pBusPal
);
	import lspcPkg::*;

	// Raster
	hCountT hCount;
	vCountT vCount;
	aaCountT aaCount;
	logic [7:0] aaSpeed;
	logic aaDisable;

	// CPU to VRAM request pair
	logic vramReq;
	logic vramWe;
	logic vramAck;
	vramAddrT vramAddr;
	vramDataT vramWrData;
	vramDataT vramRdData;

	// Fix fetch to output stage
	vramDataT fixEntry;
	logic fixValid;

	cpuRegs cpuRegs_inst (.CLK_24M(CLK_24M), .arstN(arstN), .cpuValid(cpuValid),
		.cpuWrite(cpuWrite), .cpuSel(cpuSel), .cpuWrData(cpuWrData), .cpuReady(cpuReady),
		.cpuRdData(cpuRdData), .vCount(vCount), .aaCount(aaCount), .vramAck(vramAck),
		.vramRdData(vramRdData), .vramReq(vramReq), .vramWe(vramWe), .vramAddr(vramAddr),
		.vramWrData(vramWrData), .aaSpeed(aaSpeed), .aaDisable(aaDisable));

	videoSync videoSync_inst (.CLK_24M(CLK_24M), .arstN(arstN), .aaSpeed(aaSpeed),
		.aaDisable(aaDisable), .hCount(hCount), .vCount(vCount), .hsync(hsync),
		.vblank(vblank), .csync(csync), .aaCount(aaCount));

	vramCycle vramCycle_inst (.CLK_24M(CLK_24M), .arstN(arstN), .hCount(hCount),
		.vCount(vCount), .vramReq(vramReq), .vramWe(vramWe), .vramAddr(vramAddr),
		.vramWrData(vramWrData), .vramAck(vramAck), .vramRdData(vramRdData),
		.fixEntry(fixEntry), .fixValid(fixValid));

	pBusDriver pBusDriver_inst (.CLK_24M(CLK_24M), .arstN(arstN), .hCount(hCount),
		.vCount(vCount), .fixEntry(fixEntry), .fixValid(fixValid), .pixLoad(pixLoad),
		.pBusAddr(pBusAddr), .pBusPal(pBusPal));

endmodule

`default_nettype wire

/* logic/pBusDriver.sv */
`timescale 1ns/1ns
`default_nettype none

module pBusDriver
(
	input wire CLK_24M,
	input wire arstN,
	input wire lspcPkg::hCountT hCount,
	input wire lspcPkg::vCountT vCount,
	input wire lspcPkg::vramDataT fixEntry,
	input wire fixValid,
	output logic pixLoad,
	output logic [15:0] pBusAddr,
	output lspcPkg::palT pBusPal
);
	import lspcPkg::*;

	logic b1Prev;      // hCount bit 1, last clock
	logic pck1;        // Fall of bit 1
	logic loadD;
	vramDataT fixNext; // Fetched, not yet on the bus
	fixTileT tileQ;
	palT palQ;

	assign pck1 = b1Prev & ~hCount[1];

	// Strobe and bus, one clock after the tile latch
	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
		begin
			b1Prev <= 1'b0;
			loadD <= 1'b0;
			pixLoad <= 1'b0;
			pBusAddr <= '0;
			pBusPal <= '0;
		end
		else
		begin
			b1Prev <= hCount[1];
			loadD <= pck1;
			pixLoad <= loadD; // Bus and strobe change together
			if (loadD)
			begin
				pBusAddr <= {hCount[2], vCount[2:0], tileQ}; // A4, line in tile, tile
				pBusPal <= palQ;
			end
		end
	end

	// Tile pipeline, next fetch can land while this one is shown
	always_ff @(posedge CLK_24M)
	begin
		if (fixValid)
			fixNext <= fixEntry;
		if (pck1)
		begin
			tileQ <= fixNext[11:0];
			palQ <= fixNext[15:12];
		end
	end

endmodule

`default_nettype wire

/* logic/videoSync.sv */
`timescale 1ns/1ns
`default_nettype none
`include "lspc_defs.svh"

module videoSync
(
	input wire CLK_24M,
	input wire arstN,
	input wire logic [7:0] aaSpeed,
	input wire aaDisable,
	output lspcPkg::hCountT hCount,
	output lspcPkg::vCountT vCount,
	output logic hsync,
	output logic vblank,
	output logic csync,
	output lspcPkg::aaCountT aaCount
);
	import lspcPkg::*;

	logic [1:0] subPix; // Clock within pixel
	logic lineEnd;
	logic frameEnd;
	logic vsync;
	logic vblStart;     // Clock before vblank rises
	hCountT hNext;
	vCountT vNext;
	logic [7:0] frameCnt; // Frames since last animation step

	assign lineEnd = (hCount == `LSPC_H_TOTAL - 9'd1);
	assign frameEnd = (vCount == `LSPC_V_TOTAL - 9'd1);
	assign hNext = lineEnd ? '0 : hCount + 9'd1;
	assign vNext = frameEnd ? '0 : vCount + 9'd1;
	assign vblStart = (subPix == 2'd3) && lineEnd && (vNext == `LSPC_VBL_START);

	assign csync = hsync ^ ~vsync; // Composite

	// Raster counters and syncs, all updated on the last clock of a pixel
	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
		begin
			subPix <= 2'd0;
			hCount <= '0;
			vCount <= '0;
			hsync <= 1'b0;
			vsync <= 1'b0;
			vblank <= 1'b0;
		end
		else
		begin
			subPix <= subPix + 2'd1;
			if (subPix == 2'd3)
			begin
				hCount <= hNext;
				hsync <= (hNext < `LSPC_HSYNC_END);
				if (lineEnd)
				begin
					vCount <= vNext;
					vblank <= (vNext >= `LSPC_VBL_START);
					vsync <= (vNext >= `LSPC_V_TOTAL - `LSPC_VSYNC_LINES); // Last 4 lines
				end
			end
		end
	end

	// Auto-animation frame divider
	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
		begin
			frameCnt <= '0;
			aaCount <= '0;
		end
		else if (vblStart)
		begin
			if (frameCnt >= aaSpeed) // Also catches a speed lowered mid-count
			begin
				frameCnt <= '0;
				if (!aaDisable)
					aaCount <= aaCount + 3'd1;
			end
			else
				frameCnt <= frameCnt + 8'd1;
		end
	end

	// Counters stay inside the raster
	assert property (@(posedge CLK_24M) disable iff (!arstN)
		(hCount < `LSPC_H_TOTAL) && (vCount < `LSPC_V_TOTAL));

endmodule

`default_nettype wire

/* logic/vramCycle.sv */
`timescale 1ns/1ns
`default_nettype none
`include "lspc_defs.svh"

module vramCycle
(
	input wire CLK_24M,
	input wire arstN,
	input wire lspcPkg::hCountT hCount,
	input wire lspcPkg::vCountT vCount,
	input wire vramReq,
	input wire vramWe,
	input wire lspcPkg::vramAddrT vramAddr,
	input wire lspcPkg::vramDataT vramWrData,
	output logic vramAck,
	output lspcPkg::vramDataT vramRdData,
	output lspcPkg::vramDataT fixEntry,
	output logic fixValid
);
	import lspcPkg::*;

	vramDataT vram [0:`LSPC_VRAM_WORDS-1]; // Single port array
	logic [1:0] phase; // Subpixel phase, tracks videoSync
	hCountT hPrev;
	logic cpuSlot;
	logic fixSlot;
	logic lastPix;
	hCountT nextH;
	vCountT nextV;
	vramAddrT fixAddr;
	vramAddrT memAddr;
	vramDataT memRd;

	// Phase 0 is the clock where hCount has just moved
	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
		begin
			phase <= 2'd0;
			hPrev <= '0;
		end
		else
		begin
			hPrev <= hCount;
			if (hCount != hPrev)
				phase <= 2'd1; // Resync on each pixel step
			else
				phase <= phase + 2'd1;
		end
	end

	// Slots
	// Phase 1 on the last pixel of a 4-pixel group fetches the fix map
	// Phase 3 of every pixel belongs to the CPU
	assign cpuSlot = (phase == 2'd3);
	assign fixSlot = (phase == 2'd1) && (hCount[1:0] == 2'b11);

	// Fetch targets the pixel that follows, so the tile is ready at PCK1
	assign lastPix = (hCount == `LSPC_H_TOTAL - 9'd1);
	assign nextH = lastPix ? '0 : hCount + 9'd1;
	always_comb
	begin
		if (!lastPix)
			nextV = vCount;
		else if (vCount == `LSPC_V_TOTAL - 9'd1)
			nextV = '0;
		else
			nextV = vCount + 9'd1;
	end

	// Base + column * 32 + row
	assign fixAddr = `LSPC_FIX_BASE + {4'b0000, nextH[8:3], nextV[7:3]};

	// One address for the whole array
	assign memAddr = fixSlot ? fixAddr : vramAddr;
	assign memRd = vram[memAddr];

	assign vramAck = cpuSlot & vramReq; // One clock, request drops or moves on
	assign vramRdData = memRd;          // Valid with vramAck

	always_ff @(posedge CLK_24M)
	begin
		if (cpuSlot && vramReq && vramWe)
			vram[memAddr] <= vramWrData;
		if (fixSlot)
			fixEntry <= memRd;
	end

	always_ff @(posedge CLK_24M or negedge arstN)
	begin
		if (!arstN)
			fixValid <= 1'b0;
		else
			fixValid <= fixSlot; // Once per pixel group
	end

	// CPU is granted only on the last clock of a pixel
	assert property (@(posedge CLK_24M) disable iff (!arstN)
		vramAck |=> (hCount != $past(hCount)));

endmodule

`default_nettype wire

/* sim/lspcTb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "lspc_defs.svh"

module lspcTb;
	import lspcPkg::*;

	localparam int CLK_PERIOD = 40;     // 24M stand-in, ns
	localparam int SEED_INIT = 7838;
	localparam int TXN_COUNT = 300;     // Random mix length
	localparam int TXN_BUDGET = 4000;   // Upper bound on all CPU transfers
	localparam int FRAME_BUDGET = 14;   // Animation, fix and raster waits
	localparam longint FRAME_CLKS = 4 * `LSPC_H_TOTAL * `LSPC_V_TOTAL;
	localparam longint WATCHDOG_NS =
		(FRAME_BUDGET * FRAME_CLKS + 20 * TXN_BUDGET) * CLK_PERIOD;

	logic CLK_24M;
	logic arstN;
	logic cpuValid;
	logic cpuWrite;
	regSelT cpuSel;
	vramDataT cpuWrData;
	logic cpuReady;
	vramDataT cpuRdData;
	logic hsync;
	logic vblank;
	logic csync;
	logic pixLoad;
	logic [15:0] pBusAddr;
	palT pBusPal;

	// Reference model
	vramDataT mem [0:`LSPC_VRAM_WORDS-1];
	bit known [0:`LSPC_VRAM_WORDS-1]; // Written at least once
	vramAddrT mAddr;
	vramDataT mMod;

	integer seed;
	longint rasterPos;     // Clocks since reset release
	longint lastHsyncPos;
	int hsyncSinceVbl;
	int vblRises;
	int hsyncRises;
	int issued;
	int accepted;
	int stalls;
	int fixChecks;
	bit fixOn;             // Fix map static, P-bus checked
	bit busyDue;           // Transfer taken last clock
	bit busyExp;           // That transfer started a VRAM access
	logic prevHsync;
	logic prevVbl;

	lspcTop lspcTop_inst (.CLK_24M(CLK_24M), .arstN(arstN), .cpuValid(cpuValid),
		.cpuWrite(cpuWrite), .cpuSel(cpuSel), .cpuWrData(cpuWrData), .cpuReady(cpuReady),
		.cpuRdData(cpuRdData), .hsync(hsync), .vblank(vblank), .csync(csync),
		.pixLoad(pixLoad), .pBusAddr(pBusAddr), .pBusPal(pBusPal));

	initial
	begin
		CLK_24M = 1'b0;
		forever #(CLK_PERIOD / 2) CLK_24M = ~CLK_24M;
	end

	// Raster position from the clock count alone
	function automatic int pixOf(input longint n);
		return int'((n / 4) % `LSPC_H_TOTAL);
	endfunction

	function automatic int lineOf(input longint n);
		return int'((n / (4 * `LSPC_H_TOTAL)) % `LSPC_V_TOTAL);
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
		input string msg);
		if (actual !== expected)
		begin
			$display("MISMATCH at %0t ns: %s, got %h expected %h", $time, msg, actual,
				expected);
			$display("*** FAILED ***");
			$fatal(1, "Check failed");
		end
	endtask

	// Register rules applied to one accepted transfer
	task automatic applyTransfer(input logic wr, input regSelT sel, input vramDataT data,
		input vramDataT rd, input longint n);
		if (wr)
		begin
			case (sel)
				`LSPC_REG_ADDR: mAddr = data[14:0];
				`LSPC_REG_DATA:
				begin
					mem[mAddr] = data;
					known[mAddr] = 1'b1;
					mAddr = mAddr + mMod[14:0]; // 15-bit wrap
				end
				`LSPC_REG_MOD: mMod = data;
				default: ; // Animation settings, checked through aaCount
			endcase
		end
		else
		begin
			case (sel)
				`LSPC_REG_MOD: check(32'(rd), 32'(mMod), "MOD readback");
				`LSPC_REG_MODE:
				begin
					check(32'(rd[15:7]), 32'(lineOf(n)), "MODE line number");
					check(32'(rd[6:3]), 32'd0, "MODE unused bits");
				end
				default:
					if (known[mAddr])
						check(32'(rd), 32'(mem[mAddr]), "DATA readback");
			endcase
		end
	endtask

	// One CPU transfer, held until the port takes it
	task automatic cpuXfer(input logic wr, input regSelT sel, input vramDataT data,
		output vramDataT rd);
		longint n;
		@(posedge CLK_24M);
		cpuValid <= 1'b1;
		cpuWrite <= wr;
		cpuSel <= sel;
		cpuWrData <= data;
		issued++;
		do
			@(posedge CLK_24M);
		while (!cpuReady);
		n = rasterPos; // Cycle of the transfer
		rd = cpuRdData;
		cpuValid <= 1'b0;
		applyTransfer(wr, sel, data, rd, n);
	endtask

	task automatic waitVblank(input int count);
		int target;
		target = vblRises + count;
		while (vblRises < target)
			@(posedge CLK_24M);
	endtask

	task automatic readAa(output aaCountT aa);
		vramDataT rd;
		cpuXfer(1'b0, `LSPC_REG_MODE, 16'h0000, rd);
		aa = rd[2:0];
	endtask

	// Monitor: transfer count, raster edges, P-bus
	always @(posedge CLK_24M)
	begin
		int h;
		int v;
		int fixAddr;
		if (arstN)
		begin
			h = pixOf(rasterPos);
			v = lineOf(rasterPos);
			if (cpuValid && cpuReady)
				accepted++;
			if (cpuValid && !cpuReady)
				stalls++; // Held request, must not count
			if (busyDue) // Write to ADDR or DATA leaves a VRAM access pending
				check(32'(cpuReady), 32'(!busyExp), "cpuReady after transfer");
			busyDue <= cpuValid && cpuReady;
			busyExp <= cpuWrite && (cpuSel == `LSPC_REG_ADDR || cpuSel == `LSPC_REG_DATA);
			if (hsync && !prevHsync && rasterPos >= FRAME_CLKS / `LSPC_V_TOTAL)
			begin
				check(32'(h), 32'd0, "hsync rise position");
				if (hsyncRises > 0)
					check(32'(rasterPos - lastHsyncPos), 32'(4 * `LSPC_H_TOTAL),
						"clocks per line");
				lastHsyncPos <= rasterPos;
				hsyncRises <= hsyncRises + 1;
				hsyncSinceVbl <= hsyncSinceVbl + 1;
			end
			if (vblank && !prevVbl)
			begin
				check(32'(v), 32'(`LSPC_VBL_START), "vblank rise line");
				if (vblRises > 0)
					check(32'(hsyncSinceVbl), 32'(`LSPC_V_TOTAL), "lines per frame");
				hsyncSinceVbl <= 1; // This edge's line counts
				vblRises <= vblRises + 1;
			end
			if (rasterPos >= 4) // Reset holds hsync low over the first pixel
			begin
				check(32'(hsync), 32'(h < `LSPC_HSYNC_END), "hsync level");
				check(32'(csync), 32'((h < `LSPC_HSYNC_END) ^
					(v < `LSPC_V_TOTAL - `LSPC_VSYNC_LINES)), "csync level");
			end
			if (fixOn && pixLoad && v < `LSPC_VBL_START)
			begin
				fixAddr = `LSPC_FIX_BASE + (h / 8) * 32 + (v / 8);
				check(32'(rasterPos % 16), 32'd2, "pixLoad phase"); // Group start, clock 2
				check(32'(pBusAddr[11:0]), 32'(mem[fixAddr][11:0]), "P-bus tile");
				check(32'(pBusPal), 32'(mem[fixAddr][15:12]), "P-bus palette");
				check(32'(pBusAddr[15:12]), 32'({h[2], v[2:0]}), "P-bus line bits");
				fixChecks++;
			end
			rasterPos <= rasterPos + 1;
		end
		prevHsync <= hsync;
		prevVbl <= vblank;
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("Watchdog expired before the test sequence finished");
		$display("*** FAILED ***");
		$fatal(1, "Timeout");
	end

	initial
	begin
		vramDataT rd;
		vramDataT d;
		vramAddrT a;
		vramAddrT burst[$];
		aaCountT aaBase;
		aaCountT aaNow;
		int sel;
		int speed;
		seed = SEED_INIT;
		arstN = 1'b0;
		cpuValid = 1'b0;
		cpuWrite = 1'b0;
		cpuSel = '0;
		cpuWrData = '0;
		mAddr = '0;
		mMod = '0;
		rasterPos = 0;
		lastHsyncPos = 0;
		hsyncSinceVbl = 0;
		vblRises = 0;
		hsyncRises = 0;
		issued = 0;
		accepted = 0;
		stalls = 0;
		fixChecks = 0;
		fixOn = 1'b0;
		busyDue = 1'b0;
		busyExp = 1'b0;
		prevHsync = 1'b0;
		prevVbl = 1'b0;
		repeat (5) @(posedge CLK_24M);
		arstN <= 1'b1;

		// Random mix in a small window so reads hit written words
		for (int i = 0; i < TXN_COUNT; i++)
		begin
			sel = $unsigned($random(seed)) % 6;
			d = 16'($random(seed));
			case (sel)
				0: cpuXfer(1'b1, `LSPC_REG_ADDR, d & 16'h003F, rd);
				1, 2: cpuXfer(1'b1, `LSPC_REG_DATA, d, rd);
				3: cpuXfer(1'b0, `LSPC_REG_DATA, 16'h0000, rd);
				4: cpuXfer(1'b1, `LSPC_REG_MOD, d & 16'h0003, rd);
				default: cpuXfer(1'b0, (d[0] ? `LSPC_REG_MOD : `LSPC_REG_MODE), 16'h0, rd);
			endcase
		end

		// Write then read at a fixed address sees the new word
		cpuXfer(1'b1, `LSPC_REG_MOD, 16'h0000, rd);
		for (int i = 0; i < 8; i++)
		begin
			d = 16'($random(seed));
			cpuXfer(1'b1, `LSPC_REG_ADDR, 16'($random(seed)), rd);
			cpuXfer(1'b1, `LSPC_REG_DATA, d, rd);
			cpuXfer(1'b0, `LSPC_REG_DATA, 16'h0000, rd);
			check(32'(rd), 32'(d), "read after write");
		end

		// Bursts with a nonzero modulo, wrap included
		for (int b = 0; b < 6; b++)
		begin
			cpuXfer(1'b1, `LSPC_REG_MOD, 16'($random(seed)) | 16'h0001, rd);
			cpuXfer(1'b1, `LSPC_REG_ADDR, 16'($random(seed)), rd);
			for (int i = 0; i < 8; i++)
			begin
				burst.push_back(mAddr);
				cpuXfer(1'b1, `LSPC_REG_DATA, 16'($random(seed)), rd);
			end
		end
		while (burst.size() > 0)
		begin
			a = burst.pop_front();
			cpuXfer(1'b1, `LSPC_REG_ADDR, {1'b0, a}, rd);
			cpuXfer(1'b0, `LSPC_REG_DATA, 16'h0000, rd);
			check(32'(rd), 32'(mem[a]), "burst readback");
		end

		// Auto-animation, speed 0 or 1
		speed = $unsigned($random(seed)) % 2;
		cpuXfer(1'b1, `LSPC_REG_MODE, {8'(speed), 8'h00}, rd);
		readAa(aaBase);
		aaNow = aaBase;
		while (aaNow == aaBase)
		begin
			waitVblank(1); // Align on a step
			readAa(aaNow);
		end
		for (int k = 0; k < 2; k++)
		begin
			aaBase = aaNow;
			for (int f = 1; f <= speed + 1; f++)
			begin
				waitVblank(1);
				readAa(aaNow);
				if (f <= speed)
					check(32'(aaNow), 32'(aaBase), "aaCount held between steps");
				else
					check(32'(aaNow), 32'(aaCountT'(aaBase + 3'd1)), "aaCount step");
			end
		end
		cpuXfer(1'b1, `LSPC_REG_MODE, {8'(speed), 8'h08}, rd); // Disable
		readAa(aaBase);
		for (int f = 0; f < 2; f++)
		begin
			waitVblank(1);
			readAa(aaNow);
			check(32'(aaNow), 32'(aaBase), "aaCount with disable");
		end

		// Fix map preload, whole map
		cpuXfer(1'b1, `LSPC_REG_MOD, 16'h0001, rd);
		cpuXfer(1'b1, `LSPC_REG_ADDR, {1'b0, `LSPC_FIX_BASE}, rd);
		for (int i = 0; i < 48 * 32; i++)
			cpuXfer(1'b1, `LSPC_REG_DATA, 16'($random(seed)), rd);
		repeat (16) @(posedge CLK_24M); // Old tiles leave the pipeline
		fixOn = 1'b1;
		waitVblank(2);
		fixOn = 1'b0;

		check(32'(fixChecks > 0), 32'd1, "P-bus loads seen");
		check(32'(stalls > 0), 32'd1, "back-pressure seen");
		check(32'(accepted), 32'(issued), "accepted transfer count");
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire
